// File: vlog.f
verilog/alloc_pkg.sv
verilog/alloc_free_list.sv
verilog/alloc_reg_blk.sv
verilog/alloc_ctrl_core.sv
verilog/alloc_top.sv
sim/alloc_tb_assert.sv
sim/alloc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the allocator testbench with Verilator, run it and check the log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module alloc_tb --Mdir obj_dir -o alloc_sim -f vlog.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/alloc_sim > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

// File: sim/alloc_tb.sv
/*
 * Pointer allocator testbench
 * Directed tests against a FIFO model of the free list and a counter model
 */
`timescale 1ns/1ps
`default_nettype none

module alloc_tb;
    import alloc_pkg::*;

    localparam int PTR_W       = 4;
    localparam int DEPTH       = 1 << PTR_W;
    // Six short tests stay well below this
    localparam int CYCLE_LIMIT = 4000;

    logic         clk;
    logic         dbg_cnt_reset;
    logic         en;
    logic         alloc_req;
    reg_req_t     reg_req;
    reg_rsp_t     reg_rsp;
    alloc_rsp_t   alloc_rsp;
    dealloc_req_t dealloc_req;

    // Reference model
    logic [7:0]       fl_q[$];
    logic [DEPTH-1:0] alloc_map;
    // Counter order as in the register map, entry 0 is CNT_ALLOC
    logic [31:0]      exp_cnt [NUM_CNT];
    logic [31:0]      exp_active;
    logic [1:0]       exp_flags;
    logic [7:0]       exp_alloc_err_ptr;
    logic [7:0]       exp_dealloc_err_ptr;
    logic             model_en;
    logic             model_alloc_en;

    logic [31:0] seed   = 32'h3f8941fc;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    int          cycles = 0;

    alloc_top #(
        .PTR_W ( PTR_W )
    ) UUT (
        .clk,
        .dbg_cnt_reset,
        .en,
        .reg_req,
        .reg_rsp,
        .alloc_req,
        .alloc_rsp,
        .dealloc_req
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------------
    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        @(negedge clk);
        reg_req.valid = 1'b1;
        reg_req.wr    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        @(negedge clk);
        reg_req = '0;
        if (reg_rsp.valid !== 1'b1) begin
            errors++;
            $display("No register response to the write of %s", addr.name());
        end
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        @(negedge clk);
        reg_req.valid = 1'b1;
        reg_req.wr    = 1'b0;
        reg_req.addr  = addr;
        reg_req.wdata = '0;
        @(negedge clk);
        reg_req = '0;
        data = reg_rsp.rdata;
        if (reg_rsp.valid !== 1'b1) begin
            errors++;
            $display("No register response to the read of %s", addr.name());
        end
    endtask

    task automatic check_reg(input reg_addr_e addr, input logic [31:0] exp);
        logic [31:0] got;
        reg_read(addr, got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s read 0x%08h, expected 0x%08h",
                     $time, addr.name(), got, exp);
        end
    endtask

    // Head pointer of an empty pool carries no meaning
    task automatic check_rsp(input alloc_rsp_t got, input alloc_rsp_t exp,
                             input bit cmp_ptr);
        checks++;
        if (got.valid !== exp.valid || got.fail !== exp.fail
                || (cmp_ptr && got.ptr !== exp.ptr)) begin
            errors++;
            $display("Error at %0t ns: alloc_rsp valid=%0b fail=%0b ptr=%0d, expected %0b %0b %0d",
                     $time, got.valid, got.fail, got.ptr, exp.valid, exp.fail, exp.ptr);
        end
    endtask

    task automatic check_counters();
        for (int i = 0; i < NUM_CNT; i++)
            check_reg(reg_addr_e'(CNT_ALLOC + 6'(i)), exp_cnt[i]);
        check_reg(CNT_ACTIVE, exp_active);
    endtask

    // Events reach the counters two cycles after the request
    task automatic settle();
        repeat (4) @(negedge clk);
    endtask

    task automatic set_control(input logic [2:0] bits);
        reg_write(CONTROL, {29'd0, bits});
        model_en       = en && bits[1];
        model_alloc_en = bits[2];
        settle();
    endtask

    task automatic wait_init(input logic level);
        logic [31:0] status;
        int          polls;
        polls = 0;
        reg_read(STATUS, status);
        while (status[1] !== level && polls < 100) begin
            reg_read(STATUS, status);
            polls++;
        end
        if (status[1] !== level) begin
            errors++;
            $display("init_done did not reach %0b within %0d status reads", level, polls);
        end
    endtask

    task automatic reset_model();
        fl_q.delete();
        for (int i = 0; i < DEPTH; i++)
            fl_q.push_back(8'(i));
        alloc_map  = '0;
        exp_active = '0;
        exp_flags  = '0;
        for (int i = 0; i < NUM_CNT; i++)
            exp_cnt[i] = '0;
    endtask

    // ------------------------------------------------------------------------
    // Allocate and free with model prediction
    // ------------------------------------------------------------------------
    task automatic do_alloc();
        alloc_rsp_t exp;
        bit         cmp_ptr;
        exp       = '0;
        exp.valid = 1'b1;
        cmp_ptr   = 1'b1;
        if (!(model_en && model_alloc_en)) begin
            exp.fail   = 1'b1;
            exp_cnt[2] = exp_cnt[2] + 32'd1;
            exp_flags[0] = 1'b1;
            if (fl_q.size() > 0) begin
                exp.ptr = fl_q[0];
                exp_alloc_err_ptr = fl_q[0];
            end else begin
                cmp_ptr = 1'b0;
            end
        end else if (fl_q.size() == 0) begin
            exp.fail   = 1'b1;
            exp_cnt[1] = exp_cnt[1] + 32'd1;
            cmp_ptr    = 1'b0;
        end else begin
            exp.ptr = fl_q.pop_front();
            alloc_map[exp.ptr[PTR_W-1:0]] = 1'b1;
            exp_cnt[0] = exp_cnt[0] + 32'd1;
            exp_active = exp_active + 32'd1;
        end
        @(negedge clk);
        alloc_req = 1'b1;
        @(negedge clk);
        alloc_req = 1'b0;
        check_rsp(alloc_rsp, exp, cmp_ptr);
    endtask

    task automatic do_free(input logic [7:0] ptr);
        if (!model_en) begin
            exp_cnt[4] = exp_cnt[4] + 32'd1;
        end else if (ptr < 8'(DEPTH) && alloc_map[ptr[PTR_W-1:0]]) begin
            fl_q.push_back(ptr);
            alloc_map[ptr[PTR_W-1:0]] = 1'b0;
            exp_cnt[3] = exp_cnt[3] + 32'd1;
            exp_active = exp_active - 32'd1;
        end else begin
            exp_cnt[5] = exp_cnt[5] + 32'd1;
            exp_flags[1] = 1'b1;
            exp_dealloc_err_ptr = ptr;
        end
        @(negedge clk);
        dealloc_req.valid = 1'b1;
        dealloc_req.ptr   = ptr;
        @(negedge clk);
        dealloc_req = '0;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("%-24s %s", name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic init_and_enable();
        int e0;
        e0 = errors;
        en = 1'b1;
        set_control(3'b110);
        wait_init(1'b1);
        check_reg(STATUS, 32'h6);
        check_reg(INFO_SIZE, 32'(DEPTH));
        check_reg(DBG_STATUS, {16'd0, 8'(fl_q.size()), 8'(FL_READY)});
        check_counters();
        finish_test("reset and init", e0);
    endtask

    task automatic fill_pool();
        int e0;
        e0 = errors;
        repeat (DEPTH + 1) do_alloc();
        settle();
        check_counters();
        finish_test("fill pool", e0);
    endtask

    task automatic free_and_realloc();
        int         e0;
        int         freed;
        int         tries;
        logic [7:0] p;
        e0    = errors;
        freed = 0;
        tries = 0;
        while (freed < 6 && tries < 200) begin
            seed = xorshift32(seed);
            p = {4'd0, seed[3:0]};
            if (alloc_map[p[PTR_W-1:0]]) begin
                do_free(p);
                freed++;
            end
            tries++;
        end
        settle();
        check_counters();
        // Returned pointers come back in the order they were freed
        repeat (freed) do_alloc();
        settle();
        check_counters();
        finish_test("free and reallocate", e0);
    endtask

    task automatic double_free();
        int         e0;
        logic [7:0] p;
        e0 = errors;
        seed = xorshift32(seed);
        p = {4'd0, seed[3:0]};
        do_free(p);
        do_free(p);
        settle();
        check_reg(STATUS_FLAGS, {30'd0, exp_flags});
        exp_flags = '0;
        check_reg(DEALLOC_ERR_PTR, {24'd0, exp_dealloc_err_ptr});
        check_reg(STATUS_FLAGS, 32'd0);
        check_counters();
        finish_test("double free", e0);
    endtask

    task automatic disabled_requests();
        int         e0;
        logic [7:0] p;
        e0 = errors;
        set_control(3'b010);
        do_alloc();
        settle();
        check_reg(STATUS_FLAGS, {30'd0, exp_flags});
        exp_flags = '0;
        check_reg(ALLOC_ERR_PTR, {24'd0, exp_alloc_err_ptr});
        set_control(3'b000);
        p = 8'd0;
        for (int i = DEPTH - 1; i >= 0; i--)
            if (alloc_map[i])
                p = 8'(i);
        do_free(p);
        settle();
        check_counters();
        set_control(3'b110);
        finish_test("disabled requests", e0);
    endtask

    task automatic clear_and_reset();
        int e0;
        e0 = errors;
        reg_write(DBG_CONTROL, 32'd1);
        for (int i = 0; i < NUM_CNT; i++)
            exp_cnt[i] = '0;
        settle();
        check_counters();
        check_reg(DBG_STATUS, {16'd0, 8'(fl_q.size()), 8'(FL_READY)});
        // Soft reset pulse with the block disabled, enabled again once init runs
        reg_write(CONTROL, 32'h1);
        reg_write(CONTROL, 32'h0);
        wait_init(1'b0);
        set_control(3'b110);
        wait_init(1'b1);
        reset_model();
        check_reg(STATUS, 32'h6);
        check_reg(INFO_SIZE, 32'(DEPTH));
        check_reg(DBG_STATUS, {16'd0, 8'(fl_q.size()), 8'(FL_READY)});
        check_reg(STATUS_FLAGS, 32'd0);
        check_counters();
        do_alloc();
        settle();
        check_counters();
        finish_test("clear and soft reset", e0);
    endtask

    initial begin
        dbg_cnt_reset  = 1'b1;
        en             = 1'b0;
        alloc_req      = 1'b0;
        reg_req        = '0;
        dealloc_req    = '0;
        model_en       = 1'b0;
        model_alloc_en = 1'b0;
        reset_model();
        repeat (3) @(negedge clk);
        dbg_cnt_reset = 1'b0;

        init_and_enable();
        fill_pool();
        free_and_realloc();
        double_free();
        disabled_requests();
        clear_and_reset();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : alloc_tb

`default_nettype wire

// File: sim/alloc_tb_assert.sv
/*
 * Allocator protocol assertions
 * Response timing of the register bus and allocate path, enable during reset
 */
`timescale 1ns/1ps
`default_nettype none

module alloc_tb_assert (
    input logic                  clk,
    input logic                  dbg_cnt_reset,
    input alloc_pkg::reg_req_t   reg_req,
    input alloc_pkg::reg_rsp_t   reg_rsp,
    input logic                  alloc_req,
    input alloc_pkg::alloc_rsp_t alloc_rsp,
    input logic                  ctrl_reset,
    input logic                  ctrl_en
);

    // Register response exactly one cycle after each request
    a_reg_rsp: assert property (@(posedge clk) disable iff (dbg_cnt_reset)
        reg_rsp.valid == $past(reg_req.valid))
        else $error("register response not one cycle after its request");

    // Allocate response exactly one cycle after each strobe
    a_alloc_rsp: assert property (@(posedge clk) disable iff (dbg_cnt_reset)
        alloc_rsp.valid == $past(alloc_req))
        else $error("allocate response not one cycle after its request");

    a_en_in_reset: assert property (@(posedge clk) disable iff (dbg_cnt_reset)
        ctrl_reset |-> !ctrl_en)
        else $error("ctrl_en high while ctrl_reset is high");

endmodule : alloc_tb_assert

bind alloc_top alloc_tb_assert u_alloc_assert (
    .clk           ( clk ),
    .dbg_cnt_reset ( dbg_cnt_reset ),
    .reg_req       ( reg_req ),
    .reg_rsp       ( reg_rsp ),
    .alloc_req     ( alloc_req ),
    .alloc_rsp     ( alloc_rsp ),
    .ctrl_reset    ( ctrl_reset ),
    .ctrl_en       ( ctrl_en )
);

`default_nettype wire

// File: verilog/alloc_top.sv
/*
 * Pointer allocator top level
 * Free list, control core and register block on one clock
 */
`timescale 1ns/1ps
`default_nettype none

module alloc_top #(
    parameter int PTR_W = 4
) (
    input  logic                    clk,
    input  logic                    dbg_cnt_reset,
    input  logic                    en,
    input  alloc_pkg::reg_req_t     reg_req,
    output alloc_pkg::reg_rsp_t     reg_rsp,
    input  logic                    alloc_req,
    output alloc_pkg::alloc_rsp_t   alloc_rsp,
    input  alloc_pkg::dealloc_req_t dealloc_req
);
    import alloc_pkg::*;

    logic        ctrl_reset;
    logic        ctrl_en;
    logic        ctrl_alloc_en;
    logic        init_done;
    logic [7:0]  free_cnt;
    fl_state_e   fl_state;
    alloc_mon_t  mon;
    ctrl_reg_t   ctrl;
    reg_blk_in_t blk_in;

    alloc_free_list #(
        .PTR_W ( PTR_W )
    ) i_alloc_free_list (
        .clk,
        .dbg_cnt_reset,
        .ctrl_reset,
        .ctrl_en,
        .ctrl_alloc_en,
        .alloc_req,
        .dealloc_req,
        .alloc_rsp,
        .mon,
        .init_done,
        .fl_state,
        .free_cnt
    );

    alloc_ctrl_core #(
        .PTR_W ( PTR_W )
    ) i_alloc_ctrl_core (
        .clk,
        .dbg_cnt_reset,
        .en,
        .init_done,
        .fl_state,
        .free_cnt,
        .mon,
        .ctrl,
        .ctrl_reset,
        .ctrl_en,
        .ctrl_alloc_en,
        .blk_in
    );

    alloc_reg_blk i_alloc_reg_blk (
        .clk,
        .dbg_cnt_reset,
        .reg_req,
        .reg_rsp,
        .blk_in,
        .ctrl
    );

endmodule : alloc_top

`default_nettype wire

// File: verilog/alloc_ctrl_core.sv
/*
 * Allocator control and monitoring core
 * Reset buffers, enable control, monitor pipeline stage, sticky error flags,
 * error pointers, active count and the six debug event counters
 */
`timescale 1ns/1ps
`default_nettype none

module alloc_ctrl_core #(
    parameter int PTR_W = 4
) (
    input  logic                   clk,
    input  logic                   dbg_cnt_reset,
    input  logic                   en,
    input  logic                   init_done,
    input  alloc_pkg::fl_state_e   fl_state,
    input  logic [7:0]             free_cnt,
    input  alloc_pkg::alloc_mon_t  mon,
    input  alloc_pkg::ctrl_reg_t   ctrl,
    output logic                   ctrl_reset,
    output logic                   ctrl_en,
    output logic                   ctrl_alloc_en,
    output alloc_pkg::reg_blk_in_t blk_in
);
    import alloc_pkg::*;

    localparam int DEPTH = 2**PTR_W;

    logic [1:0]               rst_buf;
    logic [1:0]               clr_buf;
    logic                     cnt_clear;
    alloc_mon_t               mon_q;
    flags_t                   flags;
    logic [7:0]               alloc_err_ptr;
    logic [7:0]               dealloc_err_ptr;
    logic [31:0]              cnt_active;
    logic [NUM_CNT-1:0][31:0] cnt;
    logic [NUM_CNT-1:0]       cnt_evt;

    // ------------------------------------------------------------------------
    // Reset buffers and control
    // ------------------------------------------------------------------------
    // Top-level reset presets both buffers
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            rst_buf <= '1;
            clr_buf <= '1;
        end else begin
            rst_buf <= {rst_buf[0], ctrl.reset};
            clr_buf <= {clr_buf[0], ctrl.reset || ctrl.clear_counts};
        end
    end

    assign ctrl_reset = rst_buf[1];
    assign cnt_clear  = clr_buf[1];

    // Enable follows the inputs one cycle later
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset)
            ctrl_en <= 1'b0;
        else
            ctrl_en <= en && ctrl.enable;
    end

    assign ctrl_alloc_en = ctrl.allocate_en;

    // Monitor pipeline stage
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset)
            mon_q <= '0;
        else
            mon_q <= mon;
    end

    // ------------------------------------------------------------------------
    // Status flags, error pointers and active count
    // ------------------------------------------------------------------------
    // A read drops the old flags but keeps an error of the same cycle
    always_ff @(posedge clk) begin
        if (ctrl_reset) begin
            flags <= '0;
        end else begin
            flags.alloc_err <= mon_q.alloc_err
                             | (flags.alloc_err & ~ctrl.status_flags_rd_evt);
            flags.dealloc_err <= mon_q.dealloc_err
                               | (flags.dealloc_err & ~ctrl.status_flags_rd_evt);
        end
    end

    always_ff @(posedge clk) begin
        if (mon_q.alloc_err)
            alloc_err_ptr <= mon_q.ptr;
        if (mon_q.dealloc_err)
            dealloc_err_ptr <= mon_q.ptr;
    end

    always_ff @(posedge clk) begin
        if (ctrl_reset)
            cnt_active <= '0;
        else
            cnt_active <= cnt_active + 32'(mon_q.alloc) - 32'(mon_q.dealloc);
    end

    // ------------------------------------------------------------------------
    // Debug counters, 32 bits and wrapping
    // ------------------------------------------------------------------------
    assign cnt_evt = {mon_q.dealloc_err, mon_q.dealloc_fail, mon_q.dealloc,
                      mon_q.alloc_err, mon_q.alloc_fail, mon_q.alloc};

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (cnt_clear)
                cnt[i] <= '0;
            else if (cnt_evt[i])
                cnt[i] <= cnt[i] + 1'b1;
        end
    end

    // To the register block
    assign blk_in.status.reset       = ctrl_reset;
    assign blk_in.status.init_done   = init_done;
    assign blk_in.status.enabled     = ctrl_en;
    assign blk_in.flags              = flags;
    assign blk_in.alloc_err_ptr      = alloc_err_ptr;
    assign blk_in.dealloc_err_ptr    = dealloc_err_ptr;
    assign blk_in.cnt_active         = cnt_active;
    assign blk_in.info_size          = 32'(DEPTH);
    assign blk_in.dbg_status.state_0 = fl_state;
    assign blk_in.dbg_status.state_1 = free_cnt;
    assign blk_in.cnt                = cnt;

endmodule : alloc_ctrl_core

`default_nettype wire

// File: verilog/alloc_reg_blk.sv
/*
 * Allocator register block
 * Decodes the same-clock register bus, holds CONTROL and DBG_CONTROL and
 * returns a registered read response one cycle after each request
 */
`timescale 1ns/1ps
`default_nettype none

module alloc_reg_blk (
    input  logic                   clk,
    input  logic                   dbg_cnt_reset,
    input  alloc_pkg::reg_req_t    reg_req,
    output alloc_pkg::reg_rsp_t    reg_rsp,
    input  alloc_pkg::reg_blk_in_t blk_in,
    output alloc_pkg::ctrl_reg_t   ctrl
);
    import alloc_pkg::*;

    reg_addr_e   addr;
    logic        wr_en;
    logic        rd_en;
    logic [2:0]  control_q;
    logic        clear_q;
    logic [2:0]  cnt_off;
    logic [31:0] rd_data;

    assign addr  = reg_addr_e'(reg_req.addr);
    assign wr_en = reg_req.valid && reg_req.wr;
    assign rd_en = reg_req.valid && !reg_req.wr;

    // Offset of a counter register from CNT_ALLOC
    assign cnt_off = 3'(reg_req.addr - 6'(CNT_ALLOC));

    // ------------------------------------------------------------------------
    // Writable registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            control_q <= '0;
            clear_q   <= 1'b0;
        end else begin
            if (wr_en && addr == CONTROL)
                control_q <= reg_req.wdata[2:0];
            // clear_counts pulses for a single cycle
            clear_q <= wr_en && (addr == DBG_CONTROL) && reg_req.wdata[0];
        end
    end

    assign ctrl.reset        = control_q[0];
    assign ctrl.enable       = control_q[1];
    assign ctrl.allocate_en  = control_q[2];
    assign ctrl.clear_counts = clear_q;

    // Flags clear on the same edge that captures them for the response
    assign ctrl.status_flags_rd_evt = rd_en && (addr == STATUS_FLAGS);

    // ------------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------------
    always_comb begin
        case (addr)
            CONTROL:         rd_data = {29'd0, control_q};
            DBG_CONTROL:     rd_data = {31'd0, clear_q};
            STATUS:          rd_data = {29'd0, blk_in.status};
            STATUS_FLAGS:    rd_data = {30'd0, blk_in.flags};
            ALLOC_ERR_PTR:   rd_data = {24'd0, blk_in.alloc_err_ptr};
            DEALLOC_ERR_PTR: rd_data = {24'd0, blk_in.dealloc_err_ptr};
            CNT_ACTIVE:      rd_data = blk_in.cnt_active;
            INFO_SIZE:       rd_data = blk_in.info_size;
            DBG_STATUS:      rd_data = {16'd0, blk_in.dbg_status};
            CNT_ALLOC,
            CNT_ALLOC_FAIL,
            CNT_ALLOC_ERR,
            CNT_DEALLOC,
            CNT_DEALLOC_FAIL,
            CNT_DEALLOC_ERR: rd_data = blk_in.cnt[cnt_off];
            // Unmapped words
            default:         rd_data = '0;
        endcase
    end

    // Response one cycle after every request, data only for reads
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset)
            reg_rsp.valid <= 1'b0;
        else
            reg_rsp.valid <= reg_req.valid;
        reg_rsp.rdata <= rd_en ? rd_data : '0;
    end

endmodule : alloc_reg_blk

`default_nettype wire

// File: verilog/alloc_free_list.sv
/*
 * Pointer free list
 * Circular FIFO of free pointers plus an allocated bitmap, filled at init,
 * serving allocate and free strobes and reporting each event to the monitor
 */
`timescale 1ns/1ps
`default_nettype none

module alloc_free_list #(
    parameter int PTR_W = 4
) (
    input  logic                    clk,
    input  logic                    dbg_cnt_reset,
    input  logic                    ctrl_reset,
    input  logic                    ctrl_en,
    input  logic                    ctrl_alloc_en,
    input  logic                    alloc_req,
    input  alloc_pkg::dealloc_req_t dealloc_req,
    output alloc_pkg::alloc_rsp_t   alloc_rsp,
    output alloc_pkg::alloc_mon_t   mon,
    output logic                    init_done,
    output alloc_pkg::fl_state_e    fl_state,
    output logic [7:0]              free_cnt
);
    import alloc_pkg::*;

    localparam int DEPTH = 2**PTR_W;

    logic [PTR_W-1:0] fifo_mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [DEPTH-1:0] allocated;
    fl_state_e        state;

    logic             ready;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] free_ptr;
    logic             free_known;
    logic             alloc_dis;
    logic             alloc_empty;
    logic             alloc_ok;
    logic             free_dis;
    logic             free_bad;
    logic             free_ok;
    alloc_rsp_t       rsp_nxt;
    alloc_mon_t       mon_nxt;

    assign ready    = (state == FL_READY);
    assign head     = fifo_mem[rd_ptr];
    assign free_ptr = dealloc_req.ptr[PTR_W-1:0];

    // Pointer is inside the pool and currently handed out
    assign free_known = ({1'b0, dealloc_req.ptr} < 9'(DEPTH)) && allocated[free_ptr];

    // Request classification
    assign alloc_dis   = alloc_req && !(ctrl_en && ctrl_alloc_en && ready);
    assign alloc_empty = alloc_req && !alloc_dis && (count == '0);
    assign alloc_ok    = alloc_req && !alloc_dis && (count != '0);

    assign free_dis = dealloc_req.valid && !(ctrl_en && ready);
    assign free_bad = dealloc_req.valid && !free_dis && !free_known;
    assign free_ok  = dealloc_req.valid && !free_dis && free_known;

    // ------------------------------------------------------------------------
    // FSM, FIFO pointers and allocated bitmap
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset || ctrl_reset) begin
            state     <= FL_RESET;
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            allocated <= '0;
        end else begin
            case (state)
                FL_RESET: state <= FL_INIT;
                FL_INIT: begin
                    // One pointer per cycle, done after the last index
                    wr_ptr <= wr_ptr + 1'b1;
                    count  <= count + 1'b1;
                    if (&wr_ptr)
                        state <= FL_READY;
                end
                FL_READY: begin
                    if (alloc_ok) begin
                        rd_ptr          <= rd_ptr + 1'b1;
                        allocated[head] <= 1'b1;
                    end
                    if (free_ok) begin
                        wr_ptr              <= wr_ptr + 1'b1;
                        allocated[free_ptr] <= 1'b0;
                    end
                    count <= count + (PTR_W+1)'(free_ok) - (PTR_W+1)'(alloc_ok);
                end
                default: state <= FL_RESET;
            endcase
        end
    end

    // Pointer storage
    always_ff @(posedge clk) begin
        if (state == FL_INIT)
            fifo_mem[wr_ptr] <= wr_ptr;
        else if (free_ok)
            fifo_mem[wr_ptr] <= free_ptr;
    end

    // ------------------------------------------------------------------------
    // Allocate response and monitor event
    // ------------------------------------------------------------------------
    always_comb begin
        rsp_nxt.valid = alloc_req;
        rsp_nxt.fail  = alloc_dis || alloc_empty;
        rsp_nxt.ptr   = 8'(head);

        mon_nxt.alloc        = alloc_ok;
        mon_nxt.alloc_fail   = alloc_empty;
        mon_nxt.alloc_err    = alloc_dis;
        mon_nxt.dealloc      = free_ok;
        mon_nxt.dealloc_fail = free_dis;
        mon_nxt.dealloc_err  = free_bad;
        // Offending free pointer wins over the head entry
        mon_nxt.ptr = free_bad ? dealloc_req.ptr : 8'(head);
    end

    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            alloc_rsp <= '0;
            mon       <= '0;
        end else begin
            alloc_rsp <= rsp_nxt;
            mon       <= mon_nxt;
        end
    end

    assign init_done = ready;
    assign fl_state  = state;
    assign free_cnt  = 8'(count);

endmodule : alloc_free_list

`default_nettype wire

// File: verilog/alloc_pkg.sv
/*
 * Pointer allocator shared definitions
 * Register bus, allocate/free and monitor structs, FSM states and register map
 */
`default_nettype none

package alloc_pkg;

    // Number of debug event counters
    localparam int NUM_CNT = 6;

    // ------------------------------------------------------------------------
    // Register bus
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic        valid;
        logic        wr;
        logic [5:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } reg_rsp_t;

    // ------------------------------------------------------------------------
    // Allocate, free and monitor
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       valid;
        logic       fail;
        logic [7:0] ptr;
    } alloc_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] ptr;
    } dealloc_req_t;

    // One cycle of allocator events
    typedef struct packed {
        logic       alloc;
        logic       alloc_fail;
        logic       alloc_err;
        logic       dealloc;
        logic       dealloc_fail;
        logic       dealloc_err;
        logic [7:0] ptr;
    } alloc_mon_t;

    typedef enum logic [7:0] {
        FL_RESET = 8'd0,
        FL_INIT  = 8'd1,
        FL_READY = 8'd2
    } fl_state_e;

    // Word addresses
    typedef enum logic [5:0] {
        CONTROL          = 6'd0,
        DBG_CONTROL      = 6'd1,
        STATUS           = 6'd2,
        STATUS_FLAGS     = 6'd3,
        ALLOC_ERR_PTR    = 6'd4,
        DEALLOC_ERR_PTR  = 6'd5,
        CNT_ACTIVE       = 6'd6,
        INFO_SIZE        = 6'd7,
        DBG_STATUS       = 6'd8,
        CNT_ALLOC        = 6'd9,
        CNT_ALLOC_FAIL   = 6'd10,
        CNT_ALLOC_ERR    = 6'd11,
        CNT_DEALLOC      = 6'd12,
        CNT_DEALLOC_FAIL = 6'd13,
        CNT_DEALLOC_ERR  = 6'd14
    } reg_addr_e;

    // ------------------------------------------------------------------------
    // Register block fields, bit 0 is the last member
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic enabled;
        logic init_done;
        logic reset;
    } status_t;

    typedef struct packed {
        logic dealloc_err;
        logic alloc_err;
    } flags_t;

    typedef struct packed {
        logic [7:0] state_1;
        logic [7:0] state_0;
    } dbg_status_t;

    typedef struct packed {
        status_t                    status;
        flags_t                     flags;
        logic [7:0]                 alloc_err_ptr;
        logic [7:0]                 dealloc_err_ptr;
        logic [31:0]                cnt_active;
        logic [31:0]                info_size;
        dbg_status_t                dbg_status;
        // Counters in register order, entry 0 is CNT_ALLOC
        logic [NUM_CNT-1:0][31:0]   cnt;
    } reg_blk_in_t;

    typedef struct packed {
        logic reset;
        logic enable;
        logic allocate_en;
        logic clear_counts;
        logic status_flags_rd_evt;
    } ctrl_reg_t;

endpackage : alloc_pkg

`default_nettype wire
